//--- build.f
+incdir+src
src/isaPkg.sv
src/ctrlPkg.sv
src/instrFields.sv
src/ctrlDecode.sv
src/regFile.sv
src/decodeStage.sv
verif/decodeStageTb.sv

//--- run.sh
#!/bin/sh
# Build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module decodeStageTb -Mdir obj_dir -f build.f
if [ $? -ne 0 ]; then
    echo "Verilator compile step did not succeed"
    exit 1
fi

output=$(./obj_dir/VdecodeStageTb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "test passed"; then
    exit 0
fi
exit 1

//--- src/ctrlDecode.sv
`include "decodeSettings.svh"

module ctrlDecode (
    input  isaPkg::instrFields_t  fields,
    output ctrlPkg::decodeCtrl_t  ctrl
);

    logic [`REG_ADDR_WIDTH-1:0] rx;
    logic [`REG_ADDR_WIDTH-1:0] ry;
    logic [`REG_ADDR_WIDTH-1:0] rz;

    // General registers live in the low eight
    assign rx = {1'b0, fields.rx};
    assign ry = {1'b0, fields.ry};
    assign rz = {1'b0, fields.rz};

    always_comb begin
        // Bubble
        ctrl.aluOp    = ctrlPkg::aluAdd;
        ctrl.operandB = ctrlPkg::opbNone;
        ctrl.memOp    = ctrlPkg::memNone;
        ctrl.branch   = ctrlPkg::brNone;
        ctrl.memToReg = 1'b1;
        ctrl.readReg1 = isaPkg::regNone;
        ctrl.readReg2 = isaPkg::regNone;
        ctrl.writeReg = isaPkg::regNone;
        ctrl.imm      = '0;

        case (fields.opcode)
            ////////////////////////////////////////////////////////////
            // Branches
            ////////////////////////////////////////////////////////////
            isaPkg::opB: begin
                ctrl.branch = ctrlPkg::brAlways;
                ctrl.imm    = fields.imm11Sext;
            end
            isaPkg::opBeqz, isaPkg::opBnez: begin
                ctrl.readReg1 = rx;
                ctrl.aluOp    = ctrlPkg::aluSub;
                ctrl.imm      = fields.imm8Sext;
                ctrl.branch   = (fields.opcode == isaPkg::opBeqz) ?
                                ctrlPkg::brIfZero : ctrlPkg::brIfNonZero;
            end

            ////////////////////////////////////////////////////////////
            // Immediate ALU
            ////////////////////////////////////////////////////////////
            isaPkg::opShift: begin
                if (fields.subCode == 2'b00 || fields.subCode == 2'b11) begin
                    ctrl.readReg1 = ry;
                    ctrl.writeReg = rx;
                    ctrl.operandB = ctrlPkg::opbImm;
                    ctrl.imm      = fields.shiftAmount;
                    ctrl.aluOp    = (fields.subCode == 2'b00) ?
                                    ctrlPkg::aluSll : ctrlPkg::aluSra;
                end
            end
            isaPkg::opAddiu3: begin
                ctrl.readReg1 = rx;
                ctrl.writeReg = ry;
                ctrl.operandB = ctrlPkg::opbImm;
                ctrl.imm      = fields.imm4Sext;
            end
            isaPkg::opAddiu: begin
                ctrl.readReg1 = rx;
                ctrl.writeReg = rx;
                ctrl.operandB = ctrlPkg::opbImm;
                ctrl.imm      = fields.imm8Sext;
            end
            isaPkg::opSltui: begin
                ctrl.readReg1 = rx;
                ctrl.writeReg = isaPkg::regT;
                ctrl.aluOp    = ctrlPkg::aluCmp;
                ctrl.operandB = ctrlPkg::opbImm;
                ctrl.imm      = fields.imm8Zext;
            end
            isaPkg::opSpGroup: begin
                case (fields.rx)
                    3'b011: begin  // ADDSP
                        ctrl.readReg1 = isaPkg::regSp;
                        ctrl.writeReg = isaPkg::regSp;
                        ctrl.operandB = ctrlPkg::opbImm;
                        ctrl.imm      = fields.imm8Sext;
                    end
                    3'b000: begin  // BTEQZ
                        ctrl.readReg1 = isaPkg::regT;
                        ctrl.aluOp    = ctrlPkg::aluSub;
                        ctrl.branch   = ctrlPkg::brIfZero;
                        ctrl.imm      = fields.imm8Sext;
                    end
                    3'b100: begin  // MTSP
                        ctrl.readReg1 = ry;
                        ctrl.writeReg = isaPkg::regSp;
                    end
                    default: ;
                endcase
            end
            isaPkg::opLi: begin
                ctrl.writeReg = rx;
                ctrl.operandB = ctrlPkg::opbImm;
                ctrl.imm      = fields.imm8Zext;
            end
            isaPkg::opMove: begin
                ctrl.readReg1 = ry;
                ctrl.writeReg = rx;
                ctrl.operandB = ctrlPkg::opbReg;
            end

            ////////////////////////////////////////////////////////////
            // Loads and stores
            ////////////////////////////////////////////////////////////
            isaPkg::opLwSp, isaPkg::opLw: begin
                ctrl.operandB = ctrlPkg::opbImm;
                ctrl.memOp    = ctrlPkg::memRead;
                ctrl.memToReg = 1'b0;
                if (fields.opcode == isaPkg::opLwSp) begin
                    ctrl.readReg1 = isaPkg::regSp;
                    ctrl.writeReg = rx;
                    ctrl.imm      = fields.imm8Sext;
                end else begin
                    ctrl.readReg1 = rx;
                    ctrl.writeReg = ry;
                    ctrl.imm      = fields.imm5Sext;
                end
            end
            isaPkg::opSwSp: begin
                ctrl.readReg1 = isaPkg::regSp;
                ctrl.readReg2 = rx;         // Store data
                ctrl.memOp    = ctrlPkg::memWrite;
                ctrl.imm      = fields.imm8Sext;
            end
            isaPkg::opSw: begin
                ctrl.readReg1 = rx;
                ctrl.readReg2 = ry;
                ctrl.operandB = ctrlPkg::opbImm;
                ctrl.memOp    = ctrlPkg::memWrite;
                ctrl.imm      = fields.imm5Sext;
            end

            ////////////////////////////////////////////////////////////
            // Register ALU
            ////////////////////////////////////////////////////////////
            isaPkg::opArith3: begin
                if (fields.subCode == 2'b01 || fields.subCode == 2'b11) begin
                    ctrl.readReg1 = rx;
                    ctrl.readReg2 = ry;
                    ctrl.writeReg = rz;
                    ctrl.operandB = ctrlPkg::opbReg;
                    ctrl.aluOp    = (fields.subCode == 2'b01) ?
                                    ctrlPkg::aluAdd : ctrlPkg::aluSub;
                end
            end
            isaPkg::opAluGroup: begin
                case (fields.subFunc)
                    5'b00000: begin
                        if (fields.ry == 3'b000) begin  // JR, MFPC dropped
                            ctrl.readReg1 = rx;
                            ctrl.branch   = ctrlPkg::brJumpReg;
                        end
                    end
                    5'b01010, 5'b00010: begin  // CMP, SLT
                        ctrl.readReg1 = rx;
                        ctrl.readReg2 = ry;
                        ctrl.writeReg = isaPkg::regT;
                        ctrl.operandB = ctrlPkg::opbReg;
                        ctrl.aluOp    = (fields.subFunc == 5'b01010) ?
                                        ctrlPkg::aluSlt : ctrlPkg::aluCmp;
                    end
                    5'b01011: begin
                        ctrl.readReg1 = ry;
                        ctrl.writeReg = rx;
                        ctrl.aluOp    = ctrlPkg::aluNeg;
                        ctrl.operandB = ctrlPkg::opbReg;
                    end
                    5'b01100, 5'b01101: begin  // AND, OR
                        ctrl.readReg1 = rx;
                        ctrl.readReg2 = ry;
                        ctrl.writeReg = rx;
                        ctrl.operandB = ctrlPkg::opbReg;
                        ctrl.aluOp    = (fields.subFunc == 5'b01100) ?
                                        ctrlPkg::aluAnd : ctrlPkg::aluOr;
                    end
                    5'b01111: begin
                        ctrl.readReg1 = ry;
                        ctrl.writeReg = rx;
                        ctrl.aluOp    = ctrlPkg::aluNot;
                    end
                    default: ;
                endcase
            end
            default: ;  // NOP and illegal words
        endcase
    end

    // Load result must come from memory
    always_comb begin
        if (ctrl.memOp == ctrlPkg::memRead) begin
            assert (ctrl.memToReg == 1'b0)
                else $error("load decoded with ALU write-back select");
        end
    end

endmodule

//--- src/ctrlPkg.sv
`include "decodeSettings.svh"

package ctrlPkg;

    typedef enum logic [3:0] {
        aluAdd = 4'b0000,
        aluSub = 4'b0001,
        aluAnd = 4'b0010,
        aluOr  = 4'b0011,
        aluNeg = 4'b0100,
        aluNot = 4'b0101,
        aluSll = 4'b0110,
        aluSra = 4'b1000,
        aluCmp = 4'b1001,
        aluSlt = 4'b1010
    } aluOp_t;

    // Second ALU operand source
    typedef enum logic [1:0] {
        opbReg  = 2'b00,
        opbImm  = 2'b01,
        opbNone = 2'b10
    } operandB_t;

    typedef enum logic [1:0] {
        memRead  = 2'b01,
        memWrite = 2'b10,
        memNone  = 2'b11
    } memOp_t;

    typedef enum logic [2:0] {
        brNone      = 3'd0,
        brAlways    = 3'd1,
        brJumpReg   = 3'd2,  // Target from readData1
        brIfZero    = 3'd3,
        brIfNonZero = 3'd4
    } branch_t;

    // Bundle handed to execute
    typedef struct packed {
        aluOp_t                     aluOp;
        operandB_t                  operandB;
        memOp_t                     memOp;
        branch_t                    branch;
        logic                       memToReg;  // Low selects memory data
        logic [`REG_ADDR_WIDTH-1:0] readReg1;
        logic [`REG_ADDR_WIDTH-1:0] readReg2;
        logic [`REG_ADDR_WIDTH-1:0] writeReg;
        logic [`DATA_WIDTH-1:0]     imm;
    } decodeCtrl_t;

endpackage

//--- src/decodeSettings.svh
`ifndef DECODE_SETTINGS_SVH
`define DECODE_SETTINGS_SVH

// Datapath and instruction sizes
`define DATA_WIDTH 16
`define INSTR_WIDTH 16

// Register file geometry
`define REG_COUNT 16
`define REG_ADDR_WIDTH 4

// Reads as zero, never written, also "no register"
`define ZERO_REG 15

`endif

//--- src/decodeStage.sv
`include "decodeSettings.svh"

module decodeStage (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [`INSTR_WIDTH-1:0]    instr,
    input  logic [`REG_ADDR_WIDTH-1:0] writeBackReg,
    input  logic [`DATA_WIDTH-1:0]     writeBackData,
    output ctrlPkg::decodeCtrl_t       ctrl,
    output logic [`DATA_WIDTH-1:0]     readData1,
    output logic [`DATA_WIDTH-1:0]     readData2,
    output logic [7:0]                 ledA,
    output logic [7:0]                 ledB
);

    isaPkg::instrFields_t fields;

    instrFields fieldSplit (
        .instr  (instr),
        .fields (fields)
    );

    ctrlDecode ctrlTable (
        .fields (fields),
        .ctrl   (ctrl)
    );

    // Write-back belongs to an older instruction
    regFile regs (
        .clk           (clk),
        .rst           (rst),
        .readReg1      (ctrl.readReg1),
        .readReg2      (ctrl.readReg2),
        .writeBackReg  (writeBackReg),
        .writeBackData (writeBackData),
        .readData1     (readData1),
        .readData2     (readData2),
        .ledA          (ledA),
        .ledB          (ledB)
    );

endmodule

//--- src/instrFields.sv
`include "decodeSettings.svh"

module instrFields (
    input  logic [`INSTR_WIDTH-1:0] instr,
    output isaPkg::instrFields_t    fields
);

    always_comb begin
        // Only known codes pass through, the rest become illegal
        case (instr[15:11])
            isaPkg::opNop, isaPkg::opB, isaPkg::opBeqz, isaPkg::opBnez,
            isaPkg::opShift, isaPkg::opAddiu3, isaPkg::opAddiu, isaPkg::opSltui,
            isaPkg::opSpGroup, isaPkg::opLi, isaPkg::opMove, isaPkg::opLwSp,
            isaPkg::opLw, isaPkg::opSwSp, isaPkg::opSw, isaPkg::opArith3,
            isaPkg::opAluGroup:
                fields.opcode = isaPkg::majorOp_t'(instr[15:11]);
            default:
                fields.opcode = isaPkg::opIllegal;
        endcase

        fields.rx      = instr[10:8];
        fields.ry      = instr[7:5];
        fields.rz      = instr[4:2];
        fields.subFunc = instr[4:0];
        fields.subCode = instr[1:0];

        ////////////////////////////////////////////////////////////
        // Immediate forms
        ////////////////////////////////////////////////////////////
        fields.imm8Sext  = {{(`DATA_WIDTH-8){instr[7]}}, instr[7:0]};
        fields.imm8Zext  = {{(`DATA_WIDTH-8){1'b0}}, instr[7:0]};
        fields.imm11Sext = {{(`DATA_WIDTH-11){instr[10]}}, instr[10:0]};
        fields.imm5Sext  = {{(`DATA_WIDTH-5){instr[4]}}, instr[4:0]};  // LW / SW offset
        fields.imm4Sext  = {{(`DATA_WIDTH-4){instr[3]}}, instr[3:0]};  // ADDIU3

        if (instr[4:2] == 3'd0) begin
            fields.shiftAmount = {{(`DATA_WIDTH-4){1'b0}}, 4'd8};
        end else begin
            fields.shiftAmount = {{(`DATA_WIDTH-3){1'b0}}, instr[4:2]};
        end
    end

endmodule

//--- src/isaPkg.sv
`include "decodeSettings.svh"

package isaPkg;

    // Major opcode, instr[15:11]
    typedef enum logic [4:0] {
        opNop      = 5'b00001,
        opB        = 5'b00010,
        opBeqz     = 5'b00100,
        opBnez     = 5'b00101,
        opShift    = 5'b00110,  // SLL / SRA by sub-code
        opAddiu3   = 5'b01000,
        opAddiu    = 5'b01001,
        opSltui    = 5'b01011,
        opSpGroup  = 5'b01100,  // ADDSP, BTEQZ, MTSP by rx field
        opLi       = 5'b01101,
        opMove     = 5'b01111,
        opLwSp     = 5'b10010,
        opLw       = 5'b10011,
        opSwSp     = 5'b11010,
        opSw       = 5'b11011,
        opArith3   = 5'b11100,  // ADDU / SUBU
        opAluGroup = 5'b11101,  // Two-register ALU ops and JR
        opIllegal  = 5'b11111
    } majorOp_t;

    // Reserved register indices
    typedef enum logic [3:0] {
        regSp   = 4'd8,
        regT    = 4'd9,
        regNone = 4'(`ZERO_REG)
    } specialReg_t;

    typedef struct packed {
        majorOp_t                opcode;
        logic [2:0]              rx;          // instr[10:8]
        logic [2:0]              ry;          // instr[7:5]
        logic [2:0]              rz;          // instr[4:2]
        logic [4:0]              subFunc;
        logic [1:0]              subCode;
        logic [`DATA_WIDTH-1:0]  imm8Sext;
        logic [`DATA_WIDTH-1:0]  imm8Zext;
        logic [`DATA_WIDTH-1:0]  imm11Sext;
        logic [`DATA_WIDTH-1:0]  imm5Sext;
        logic [`DATA_WIDTH-1:0]  imm4Sext;
        logic [`DATA_WIDTH-1:0]  shiftAmount; // Field of 0 means 8
    } instrFields_t;

endpackage

//--- src/regFile.sv
`include "decodeSettings.svh"

module regFile (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [`REG_ADDR_WIDTH-1:0] readReg1,
    input  logic [`REG_ADDR_WIDTH-1:0] readReg2,
    input  logic [`REG_ADDR_WIDTH-1:0] writeBackReg,
    input  logic [`DATA_WIDTH-1:0]     writeBackData,
    output logic [`DATA_WIDTH-1:0]     readData1,
    output logic [`DATA_WIDTH-1:0]     readData2,
    output logic [7:0]                 ledA,
    output logic [7:0]                 ledB
);

    localparam logic [`REG_ADDR_WIDTH-1:0] zeroReg = `ZERO_REG;

    logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (writeBackReg != zeroReg) begin
            regs[writeBackReg] <= writeBackData;
        end
    end

    // Zero index first, then same-cycle write-back
    function automatic logic [`DATA_WIDTH-1:0] readPort(
        input logic [`REG_ADDR_WIDTH-1:0] idx
    );
        if (idx == zeroReg) return '0;
        if (idx == writeBackReg) return writeBackData;
        return regs[idx];
    endfunction

    always_comb begin
        readData1 = readPort(readReg1);
        readData2 = readPort(readReg2);
    end

    assign ledA = {regs[6][3:0], regs[4][3:0]};
    assign ledB = {regs[1][3:0], regs[0][3:0]};  // Board switch view

    // Write to the zero index leaves its storage untouched
    assert property (@(posedge clk) disable iff (!rst)
        writeBackReg == zeroReg |=> $stable(regs[`ZERO_REG]))
        else $error("write to zero register changed storage");

endmodule

//--- verif/decodeStageTb.sv
`include "decodeSettings.svh"

module decodeStageTb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [`REG_ADDR_WIDTH-1:0] noReg = 4'(`ZERO_REG);
    localparam logic [`REG_ADDR_WIDTH-1:0] spReg = 4'd8;
    localparam logic [`REG_ADDR_WIDTH-1:0] tReg  = 4'd9;
    localparam int cycleLimit = 1000;  // About 630 test cycles plus margin

    // Kept major opcodes, NOP included
    localparam logic [4:0] keptOps [17] = '{
        5'b00001, 5'b00010, 5'b00100, 5'b00101, 5'b00110, 5'b01000,
        5'b01001, 5'b01011, 5'b01100, 5'b01101, 5'b01111, 5'b10010,
        5'b10011, 5'b11010, 5'b11011, 5'b11100, 5'b11101
    };
    localparam logic [4:0] aluFuncs [7] = '{
        5'b00000, 5'b01010, 5'b00010, 5'b01011, 5'b01100, 5'b01101, 5'b01111
    };
    localparam logic [2:0] spFuncs [3] = '{3'b011, 3'b000, 3'b100};
    localparam logic [3:0] resetWrites [4] = '{4'd0, 4'd1, 4'd4, 4'd6};  // LED sources

    logic                       clk;
    logic                       rst;
    logic [`INSTR_WIDTH-1:0]    instr;
    logic [`REG_ADDR_WIDTH-1:0] writeBackReg;
    logic [`DATA_WIDTH-1:0]     writeBackData;
    ctrlPkg::decodeCtrl_t       ctrl;
    logic [`DATA_WIDTH-1:0]     readData1;
    logic [`DATA_WIDTH-1:0]     readData2;
    logic [7:0]                 ledA;
    logic [7:0]                 ledB;

    logic [`DATA_WIDTH-1:0] model [`REG_COUNT];  // Register file model
    int    errorCount = 0;
    int    checkCount = 0;
    int    cycleCount = 0;
    string testName = "reset";

    decodeStage UUT (
        .clk           (clk),
        .rst           (rst),
        .instr         (instr),
        .writeBackReg  (writeBackReg),
        .writeBackData (writeBackData),
        .ctrl          (ctrl),
        .readData1     (readData1),
        .readData2     (readData2),
        .ledA          (ledA),
        .ledB          (ledB)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
    end

    initial begin
        wait (cycleCount >= cycleLimit);
        $display("timeout: tests did not finish");
        $display("test failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////
    function automatic ctrlPkg::decodeCtrl_t ctrlRow(
        input logic [3:0]         rd1,
        input logic [3:0]         rd2,
        input logic [3:0]         wr,
        input ctrlPkg::aluOp_t    alu,
        input ctrlPkg::operandB_t opb,
        input logic [15:0]        imm
    );
        ctrlPkg::decodeCtrl_t c;
        c.aluOp    = alu;
        c.operandB = opb;
        c.memOp    = ctrlPkg::memNone;
        c.branch   = ctrlPkg::brNone;
        c.memToReg = 1'b1;
        c.readReg1 = rd1;
        c.readReg2 = rd2;
        c.writeReg = wr;
        c.imm      = imm;
        return c;
    endfunction

    function automatic ctrlPkg::decodeCtrl_t expectedCtrl(input logic [15:0] w);
        ctrlPkg::decodeCtrl_t c;
        logic [3:0]  x;
        logic [3:0]  y;
        logic [3:0]  z;
        logic [15:0] s8;
        logic [15:0] z8;
        logic [15:0] s11;
        logic [15:0] s5;
        logic [15:0] s4;
        logic [15:0] sh;
        x   = {1'b0, w[10:8]};
        y   = {1'b0, w[7:5]};
        z   = {1'b0, w[4:2]};
        s8  = {{8{w[7]}}, w[7:0]};
        z8  = {8'd0, w[7:0]};
        s11 = {{5{w[10]}}, w[10:0]};
        s5  = {{11{w[4]}}, w[4:0]};
        s4  = {{12{w[3]}}, w[3:0]};
        sh  = (w[4:2] == 3'd0) ? 16'd8 : {13'd0, w[4:2]};  // Zero shifts by 8
        c   = ctrlRow(noReg, noReg, noReg, ctrlPkg::aluAdd, ctrlPkg::opbNone, '0);
        case (w[15:11])
            5'b00010: begin
                c.imm    = s11;
                c.branch = ctrlPkg::brAlways;
            end
            5'b00100, 5'b00101: begin
                c = ctrlRow(x, noReg, noReg, ctrlPkg::aluSub, ctrlPkg::opbNone, s8);
                c.branch = w[11] ? ctrlPkg::brIfNonZero : ctrlPkg::brIfZero;
            end
            5'b00110: begin
                if (w[1:0] == 2'b00)
                    c = ctrlRow(y, noReg, x, ctrlPkg::aluSll, ctrlPkg::opbImm, sh);
                else if (w[1:0] == 2'b11)
                    c = ctrlRow(y, noReg, x, ctrlPkg::aluSra, ctrlPkg::opbImm, sh);
            end
            5'b01000: c = ctrlRow(x, noReg, y, ctrlPkg::aluAdd, ctrlPkg::opbImm, s4);
            5'b01001: c = ctrlRow(x, noReg, x, ctrlPkg::aluAdd, ctrlPkg::opbImm, s8);
            5'b01011: c = ctrlRow(x, noReg, tReg, ctrlPkg::aluCmp, ctrlPkg::opbImm, z8);
            5'b01100: begin
                if (w[10:8] == 3'b011) begin
                    c = ctrlRow(spReg, noReg, spReg, ctrlPkg::aluAdd, ctrlPkg::opbImm, s8);
                end else if (w[10:8] == 3'b000) begin
                    c = ctrlRow(tReg, noReg, noReg, ctrlPkg::aluSub, ctrlPkg::opbNone, s8);
                    c.branch = ctrlPkg::brIfZero;
                end else if (w[10:8] == 3'b100) begin
                    c = ctrlRow(y, noReg, spReg, ctrlPkg::aluAdd, ctrlPkg::opbNone, '0);
                end
            end
            5'b01101: c = ctrlRow(noReg, noReg, x, ctrlPkg::aluAdd, ctrlPkg::opbImm, z8);
            5'b01111: c = ctrlRow(y, noReg, x, ctrlPkg::aluAdd, ctrlPkg::opbReg, '0);
            5'b10010, 5'b10011: begin
                if (w[11])
                    c = ctrlRow(x, noReg, y, ctrlPkg::aluAdd, ctrlPkg::opbImm, s5);
                else
                    c = ctrlRow(spReg, noReg, x, ctrlPkg::aluAdd, ctrlPkg::opbImm, s8);
                c.memOp    = ctrlPkg::memRead;
                c.memToReg = 1'b0;
            end
            5'b11010: begin
                c = ctrlRow(spReg, x, noReg, ctrlPkg::aluAdd, ctrlPkg::opbNone, s8);
                c.memOp = ctrlPkg::memWrite;
            end
            5'b11011: begin
                c = ctrlRow(x, y, noReg, ctrlPkg::aluAdd, ctrlPkg::opbImm, s5);
                c.memOp = ctrlPkg::memWrite;
            end
            5'b11100: begin
                if (w[1:0] == 2'b01)
                    c = ctrlRow(x, y, z, ctrlPkg::aluAdd, ctrlPkg::opbReg, '0);
                else if (w[1:0] == 2'b11)
                    c = ctrlRow(x, y, z, ctrlPkg::aluSub, ctrlPkg::opbReg, '0);
            end
            5'b11101: begin
                case (w[4:0])
                    5'b00000: begin
                        if (w[7:5] == 3'b000) begin  // JR only
                            c.readReg1 = x;
                            c.branch   = ctrlPkg::brJumpReg;
                        end
                    end
                    5'b01010: c = ctrlRow(x, y, tReg, ctrlPkg::aluSlt, ctrlPkg::opbReg, '0);
                    5'b00010: c = ctrlRow(x, y, tReg, ctrlPkg::aluCmp, ctrlPkg::opbReg, '0);
                    5'b01011: c = ctrlRow(y, noReg, x, ctrlPkg::aluNeg, ctrlPkg::opbReg, '0);
                    5'b01100: c = ctrlRow(x, y, x, ctrlPkg::aluAnd, ctrlPkg::opbReg, '0);
                    5'b01101: c = ctrlRow(x, y, x, ctrlPkg::aluOr, ctrlPkg::opbReg, '0);
                    5'b01111: c = ctrlRow(y, noReg, x, ctrlPkg::aluNot, ctrlPkg::opbNone, '0);
                    default: ;
                endcase
            end
            default: ;
        endcase
        return c;
    endfunction

    function automatic logic [15:0] expectedRead(
        input logic [3:0]  idx,
        input logic [3:0]  wbReg,
        input logic [15:0] wbData
    );
        if (idx == noReg)
            return '0;
        if (idx == wbReg)
            return wbData;  // Same-cycle forwarding
        return model[idx];
    endfunction

    ////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////
    function automatic logic [15:0] regOpWord(
        input logic [2:0] rx,
        input logic [2:0] ry,
        input logic [2:0] rz,
        input bit         useAddu
    );
        if (useAddu)
            return {5'b11100, rx, ry, rz, 2'b01};
        return {5'b01111, rx, ry, 5'b00000};
    endfunction

    function automatic logic [15:0] randomDecodeWord();
        logic [15:0] w;
        logic [4:0]  opIdx;
        logic [2:0]  funcIdx;
        logic [1:0]  spIdx;
        w       = 16'($urandom);
        opIdx   = 5'($urandom_range(0, 16));
        funcIdx = 3'($urandom_range(0, 6));
        spIdx   = 2'($urandom_range(0, 2));
        if ($urandom_range(0, 9) < 7)
            w[15:11] = keptOps[opIdx];
        if (w[15:11] == 5'b11101 && $urandom_range(0, 3) != 0) begin
            w[4:0] = aluFuncs[funcIdx];
            if (w[4:0] == 5'b00000)
                w[7:5] = 3'b000;
        end
        if (w[15:11] == 5'b01100 && $urandom_range(0, 3) != 0)
            w[10:8] = spFuncs[spIdx];
        return w;
    endfunction

    task automatic reportError(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        errorCount++;
        $display("Error %s %s: expected %h, actual %h", testName, what, expected, actual);
    endtask

    // One cycle: drive on the falling edge, check reads before and LEDs after the write
    task automatic runCycle(
        input logic [`INSTR_WIDTH-1:0]    word,
        input logic [`REG_ADDR_WIDTH-1:0] wbReg,
        input logic [`DATA_WIDTH-1:0]     wbData,
        input bit                         dropped
    );
        ctrlPkg::decodeCtrl_t expCtrl;
        ctrlPkg::decodeCtrl_t bubble;
        logic [15:0]          exp1;
        logic [15:0]          exp2;
        @(negedge clk);
        instr         = word;
        writeBackReg  = wbReg;
        writeBackData = wbData;
        expCtrl = expectedCtrl(word);
        bubble  = ctrlRow(noReg, noReg, noReg, ctrlPkg::aluAdd, ctrlPkg::opbNone, '0);
        exp1    = expectedRead(expCtrl.readReg1, wbReg, wbData);
        exp2    = expectedRead(expCtrl.readReg2, wbReg, wbData);
        #40;
        checkCount += 3;
        if (ctrl !== expCtrl)
            reportError("ctrl", 64'(expCtrl), 64'(ctrl));
        if (readData1 !== exp1)
            reportError("readData1", 64'(exp1), 64'(readData1));
        if (readData2 !== exp2)
            reportError("readData2", 64'(exp2), 64'(readData2));
        if (dropped) begin
            checkCount++;
            if (ctrl !== bubble)
                reportError("bubble", 64'(bubble), 64'(ctrl));
        end
        if (wbReg != noReg)
            model[wbReg] = wbData;
        #50;  // Just before the next falling edge
        checkCount += 2;
        if (ledA !== {model[6][3:0], model[4][3:0]})
            reportError("ledA", 64'({model[6][3:0], model[4][3:0]}), 64'(ledA));
        if (ledB !== {model[1][3:0], model[0][3:0]})
            reportError("ledB", 64'({model[1][3:0], model[0][3:0]}), 64'(ledB));
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////
    initial begin
        logic [`REG_ADDR_WIDTH-1:0] wbReg;
        logic [2:0]                 sel;
        logic [2:0]                 rxField;
        logic [15:0]                word;
        void'($urandom(32'h1915));
        rst           = 1'b0;
        instr         = '0;
        writeBackReg  = noReg;
        writeBackData = '0;
        for (int i = 0; i < `REG_COUNT; i++)
            model[i] = '0;

        // Write-backs during reset must not land
        for (int i = 0; i < 4; i++) begin
            writeBackReg  = resetWrites[i];
            writeBackData = 16'($urandom) | 16'h0001;
            @(negedge clk);
        end
        rst          = 1'b1;
        writeBackReg = noReg;

        // Every low register reads zero, no write-back
        for (int i = 0; i < 8; i++)
            runCycle(regOpWord(3'(i), 3'(7 - i), 3'(i), 1'(i)), noReg, 16'($urandom), 1'b0);

        testName = "writeRead";
        for (int i = 0; i < 200; i++) begin
            runCycle(regOpWord(3'($urandom), 3'($urandom), 3'($urandom), 1'($urandom)),
                     4'($urandom), 16'($urandom), 1'b0);
        end

        testName = "forward";
        for (int i = 0; i < 100; i++) begin
            wbReg = ($urandom_range(0, 7) == 0) ? noReg : {1'b0, 3'($urandom)};
            sel   = wbReg[2:0];
            runCycle(regOpWord(sel, sel, 3'($urandom), 1'($urandom)), wbReg,
                     16'($urandom), 1'b0);
        end

        testName = "decode";
        for (int i = 0; i < 300; i++)
            runCycle(randomDecodeWord(), 4'($urandom), 16'($urandom), 1'b0);

        testName = "dropped";
        for (int i = 0; i < 12; i++) begin
            rxField = 3'($urandom);
            case (i % 3)
                0: word = {5'b11101, rxField, 3'b010, 5'b00000};     // MFPC
                1: word = {5'b11110, rxField, 3'b000, 5'b00000};     // MFIH
                default: word = {5'b11110, rxField, 3'b000, 5'b00001};
            endcase
            runCycle(word, 4'($urandom), 16'($urandom), 1'b1);
        end

        $display("errors: %0d, checks: %0d", errorCount, checkCount);
        if (errorCount == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule
